// ==== list.f ====
+incdir+hw
hw/lenet_pkg.sv
hw/window_feeder.sv
hw/pe_array.sv
hw/pool_quant.sv
hw/conv_pool_top.sv
verif/conv_pool_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the conv/pool testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f list.f \
    --top-module conv_pool_tb \
    -Mdir obj_dir -o conv_pool_sim \
    && ./obj_dir/conv_pool_sim | tee /dev/stderr | grep -qx "Testbench passed" \
    && echo "simulation ok" \
    || { echo "simulation not ok"; exit 1; }

exit 0

// ==== verif/conv_pool_tb.sv ====
`timescale 1ns/1ns
`include "lenet_defines.svh"

module conv_pool_tb;

    typedef lenet_pkg::act_row_u    [`LENET_FRAME_ROWS-1:0] act_frame_t;
    typedef lenet_pkg::weight_row_t [`LENET_KERNEL-1:0]     weight_frame_t;

    // frame content kinds
    localparam int RANDOM   = 0;
    localparam int NEGATIVE = 1;
    localparam int BIG_POS  = 2;
    localparam int BIG_NEG  = 3;

    localparam int LATENCY  = 4;
    localparam int DRAIN_TO = 200;

    logic                          clk;
    logic                          rst_n_n;
    logic                          row_valid;
    logic                          row_first;
    lenet_pkg::act_row_u           act_words;
    lenet_pkg::weight_row_t        weight_row;
    logic                          relu_en;
    logic [`LENET_SCALE_BITS-1:0]  scale;
    logic                          result_valid;
    lenet_pkg::pool_result_t       result;

    logic [31:0]                   lfsr_state;
    int                            cycle_cnt = 0;
    int                            result_errors = 0;
    int                            latency_errors = 0;
    int                            timeout_errors = 0;
    int                            other_errors = 0;

    // expected results and the edge number that sampled beat 5
    lenet_pkg::pool_result_t       exp_q [$];
    int                            edge_q [$];

    conv_pool_top uut (
        .clk          (clk),
        .rst_n_n      (rst_n_n),
        .row_valid    (row_valid),
        .row_first    (row_first),
        .act_words    (act_words),
        .weight_row   (weight_row),
        .relu_en      (relu_en),
        .scale        (scale),
        .result_valid (result_valid),
        .result       (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // expected packed word for one frame
    function automatic lenet_pkg::pool_result_t ref_frame(
        input act_frame_t                   acts,
        input weight_frame_t                wts,
        input logic                         relu,
        input logic [`LENET_SCALE_BITS-1:0] scl
    );
        int                      sum [0:1][0:3];
        int                      best;
        longint                  scl_l;
        longint                  scaled;
        lenet_pkg::pixel_t       q [0:1];
        lenet_pkg::pool_result_t res;
        scl_l = scl;
        for (int r = 0; r < 2; r++) begin
            for (int c = 0; c < 4; c++) begin
                sum[r][c] = 0;
                // lower PE row starts one activation row later
                for (int k = 0; k < `LENET_KERNEL; k++) begin
                    for (int i = 0; i < `LENET_KERNEL; i++) begin
                        sum[r][c] += int'(wts[k][i]) * int'(acts[r+k].pixels[c+i]);
                    end
                end
                if (relu && sum[r][c] < 0) begin
                    sum[r][c] = 0;
                end
            end
        end
        for (int p = 0; p < 2; p++) begin
            best = sum[0][2*p];
            if (sum[0][2*p+1] > best) best = sum[0][2*p+1];
            if (sum[1][2*p] > best) best = sum[1][2*p];
            if (sum[1][2*p+1] > best) best = sum[1][2*p+1];
            scaled = (longint'(best) * scl_l) >>> `LENET_QUANT_SHIFT;
            if (scaled > 127) begin
                q[p] = 8'sd127;
            end else if (scaled < -128) begin
                q[p] = -8'sd128;
            end else begin
                q[p] = 8'(scaled);
            end
        end
        res.pad = '0;
        res.q1  = q[1];
        res.q0  = q[0];
        return res;
    endfunction

    task automatic check_result(
        input lenet_pkg::pool_result_t got,
        input lenet_pkg::pool_result_t exp
    );
        if (got !== exp) begin
            result_errors++;
            $display("** Error at %0t: result %h, expected %h (q1 %0d/%0d, q0 %0d/%0d)",
                     $time, got, exp, got.q1, exp.q1, got.q0, exp.q0);
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got !== exp) begin
            latency_errors++;
            $display("** Error at %0t: result %0d cycles after beat 5, expected %0d",
                     $time, got, exp);
        end
    endtask

    task automatic make_frame(
        input  int            mode,
        output act_frame_t    acts,
        output weight_frame_t wts
    );
        for (int r = 0; r < `LENET_FRAME_ROWS; r++) begin
            for (int p = 0; p < `LENET_ROW_PIXELS; p++) begin
                if (mode == RANDOM) acts[r].pixels[p] = 8'(rand_bits(8));
                else if (mode == NEGATIVE) acts[r].pixels[p] = {1'b0, 7'(rand_bits(7))};
                else acts[r].pixels[p] = 8'sd127;
            end
        end
        for (int k = 0; k < `LENET_KERNEL; k++) begin
            for (int i = 0; i < `LENET_KERNEL; i++) begin
                // negative weights against positive pixels give negative sums
                if (mode == RANDOM) wts[k][i] = 8'(rand_bits(8));
                else if (mode == NEGATIVE) wts[k][i] = {1'b1, 7'(rand_bits(7))};
                else if (mode == BIG_POS) wts[k][i] = 8'sd127;
                else wts[k][i] = -8'sd128;
            end
        end
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic send_frame(
        input act_frame_t    acts,
        input weight_frame_t wts,
        input int            gap_bits
    );
        int gap;
        for (int b = 0; b < `LENET_FRAME_ROWS; b++) begin
            gap = (gap_bits > 0) ? int'(rand_bits(gap_bits)) : 0;
            row_valid = 1'b0;
            row_first = 1'b0;
            repeat (gap) @(negedge clk);
            row_valid = 1'b1;
            row_first = (b == 0);
            act_words = acts[b];
            // weight on beat 5 is don't care
            weight_row = (b < `LENET_KERNEL) ? wts[b] : {8'(rand_bits(8)), rand_bits(32)};
            if (b == `LENET_FRAME_ROWS - 1) begin
                exp_q.push_back(ref_frame(acts, wts, relu_en, scale));
                edge_q.push_back(cycle_cnt + 1);
            end
            @(negedge clk);
        end
        row_valid = 1'b0;
        row_first = 1'b0;
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < DRAIN_TO) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0) begin
            timeout_errors++;
            $display("timeout: %0d expected results never arrived", exp_q.size());
            exp_q.delete();
            edge_q.delete();
        end
    endtask

    // compare every result as it leaves the DUT
    always @(negedge clk) begin
        lenet_pkg::pool_result_t exp_res;
        int                      exp_edge;
        if (rst_n_n && result_valid) begin
            if (exp_q.size() == 0) begin
                other_errors++;
                $display("result_valid pulsed at %0t with no frame outstanding", $time);
            end else begin
                exp_res  = exp_q.pop_front();
                exp_edge = edge_q.pop_front();
                check_result(result, exp_res);
                check_latency(cycle_cnt + 1 - exp_edge, LATENCY);
            end
        end
    end

    initial begin
        act_frame_t    acts;
        weight_frame_t wts;
        act_frame_t    keep_acts [0:2];
        weight_frame_t keep_wts [0:2];
        lfsr_state = 32'had844c03;
        rst_n_n    = 1'b0;
        row_valid  = 1'b0;
        row_first  = 1'b0;
        act_words  = '0;
        weight_row = '0;
        relu_en    = 1'b1;
        scale      = 16'h0020;
        repeat (10) @(negedge clk);
        rst_n_n = 1'b1;

        // idle, the monitor flags any stray pulse
        repeat (20) @(negedge clk);

        for (int f = 0; f < 8; f++) begin
            make_frame(RANDOM, acts, wts);
            send_frame(acts, wts, 0);
        end
        wait_drain();

        relu_en = 1'b0;
        scale   = 16'h0040;
        for (int f = 0; f < 4; f++) begin
            make_frame(NEGATIVE, acts, wts);
            send_frame(acts, wts, 0);
        end
        wait_drain();

        // saturation both ways
        relu_en = 1'b1;
        scale   = 16'hffff;
        make_frame(BIG_POS, acts, wts);
        send_frame(acts, wts, 0);
        wait_drain();
        relu_en = 1'b0;
        make_frame(BIG_NEG, acts, wts);
        send_frame(acts, wts, 0);
        wait_drain();

        // same frames without and with gaps
        relu_en = 1'b1;
        scale   = 16'h0020;
        for (int f = 0; f < 3; f++) begin
            make_frame(RANDOM, keep_acts[f], keep_wts[f]);
            send_frame(keep_acts[f], keep_wts[f], 0);
        end
        wait_drain();
        for (int f = 0; f < 3; f++) begin
            send_frame(keep_acts[f], keep_wts[f], 2);
        end
        wait_drain();

        repeat (5) @(negedge clk);
        $display("result errors: %0d, latency errors: %0d, timeouts: %0d, other errors: %0d",
                 result_errors, latency_errors, timeout_errors, other_errors);
        if (result_errors + latency_errors + timeout_errors + other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// ==== hw/conv_pool_top.sv ====
`timescale 1ns/1ns
`include "lenet_defines.svh"

module conv_pool_top (
    input  logic                          clk,
    input  logic                          rst_n_n,
    input  logic                          row_valid,
    input  logic                          row_first,
    input  lenet_pkg::act_row_u           act_words,
    input  lenet_pkg::weight_row_t        weight_row,
    input  logic                          relu_en,
    input  logic [`LENET_SCALE_BITS-1:0]  scale,
    output logic                          result_valid,
    output lenet_pkg::pool_result_t       result
);

    // feeder to array, one beat per cycle at most
    lenet_pkg::feed_t feed;

    // finished frame totals, held until the next frame ends
    lenet_pkg::sums_t sums;

    window_feeder feeder (
        .clk        (clk),
        .rst_n_n    (rst_n_n),
        .row_valid  (row_valid),
        .row_first  (row_first),
        .act_words  (act_words),
        .weight_row (weight_row),
        .feed       (feed)
    );

    pe_array array (
        .clk     (clk),
        .rst_n_n (rst_n_n),
        .feed    (feed),
        .sums    (sums)
    );

    // relu, pooling and int8 quantiser
    pool_quant quant (
        .clk          (clk),
        .rst_n_n      (rst_n_n),
        .sums         (sums),
        .relu_en      (relu_en),
        .scale        (scale),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

// ==== hw/pool_quant.sv ====
`timescale 1ns/1ns
`include "lenet_defines.svh"

module pool_quant (
    input  logic                          clk,
    input  logic                          rst_n_n,
    input  lenet_pkg::sums_t              sums,
    input  logic                          relu_en,
    input  logic [`LENET_SCALE_BITS-1:0]  scale,
    output logic                          result_valid,
    output lenet_pkg::pool_result_t       result
);

    localparam int ROWS      = `LENET_PE_ROWS;
    localparam int COLS      = `LENET_PE_COLS;
    localparam int POOLS     = COLS / 2;
    localparam int PROD_BITS = `LENET_PARTIAL_BITS + `LENET_SCALE_BITS + 1;
    localparam int SAT_MAX   = (1 << (`LENET_PIXEL_BITS - 1)) - 1;
    localparam int SAT_MIN   = -(1 << (`LENET_PIXEL_BITS - 1));

    lenet_pkg::partial_t [ROWS-1:0][COLS-1:0] act;
    lenet_pkg::partial_t [POOLS-1:0]          pooled;
    lenet_pkg::partial_t [POOLS-1:0]          pool_q;
    logic                                     pool_valid;
    lenet_pkg::pixel_t [POOLS-1:0]            quant;
    lenet_pkg::pixel_t [POOLS-1:0]            quant_q;

    function automatic lenet_pkg::partial_t relu(
        input lenet_pkg::partial_t v,
        input logic                on
    );
        return (on && v < 0) ? '0 : v;
    endfunction

    function automatic lenet_pkg::partial_t max2(
        input lenet_pkg::partial_t a,
        input lenet_pkg::partial_t b
    );
        return (a > b) ? a : b;
    endfunction

    // scale, shift down, then clamp into int8
    function automatic lenet_pkg::pixel_t quantise(
        input lenet_pkg::partial_t          v,
        input logic [`LENET_SCALE_BITS-1:0] s
    );
        logic signed [PROD_BITS-1:0] prod;
        logic signed [PROD_BITS-1:0] shifted;
        prod    = v * $signed({1'b0, s});
        shifted = prod >>> `LENET_QUANT_SHIFT;
        if (shifted > SAT_MAX) begin
            return lenet_pkg::pixel_t'(SAT_MAX);
        end
        if (shifted < SAT_MIN) begin
            return lenet_pkg::pixel_t'(SAT_MIN);
        end
        return shifted[`LENET_PIXEL_BITS-1:0];
    endfunction

    always_comb begin
        for (int r = 0; r < ROWS; r++) begin
            for (int c = 0; c < COLS; c++) begin
                act[r][c] = relu(sums.pe[r][c], relu_en);
            end
        end
        // 2x2 window over both PE rows and a column pair
        for (int p = 0; p < POOLS; p++) begin
            pooled[p] = max2(max2(act[0][2*p], act[0][2*p+1]),
                             max2(act[1][2*p], act[1][2*p+1]));
        end
    end

    always_comb begin
        for (int p = 0; p < POOLS; p++) begin
            quant[p] = quantise(pool_q[p], scale);
        end
    end

    always_ff @(posedge clk) begin
        if (sums.valid) begin
            pool_q <= pooled;
        end
        if (pool_valid) begin
            quant_q <= quant;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_n) begin
            pool_valid   <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            pool_valid   <= sums.valid;
            result_valid <= pool_valid;
        end
    end

    always_comb begin
        result.pad = '0;
        result.q1  = quant_q[1];
        result.q0  = quant_q[0];
    end

    // rectified sums never quantise to a negative byte
    relu_non_negative: assert property (
        @(posedge clk) disable iff (!rst_n_n)
        (sums.valid && relu_en) |-> ##2 (!result.q0[7] && !result.q1[7])
    );

endmodule

// ==== hw/pe_array.sv ====
`timescale 1ns/1ns
`include "lenet_defines.svh"

module pe_array (
    input  logic              clk,
    input  logic              rst_n_n,
    input  lenet_pkg::feed_t  feed,
    output lenet_pkg::sums_t  sums
);

    localparam int ROWS = `LENET_PE_ROWS;
    localparam int COLS = `LENET_PE_COLS;

    lenet_pkg::partial_t [ROWS-1:0][COLS-1:0] acc;
    lenet_pkg::partial_t [ROWS-1:0][COLS-1:0] acc_next;
    lenet_pkg::partial_t [ROWS-1:0][COLS-1:0] snap;
    logic                                     snap_valid;

    // five-tap product of one weight row and the window starting at col
    function automatic lenet_pkg::partial_t dot5(
        input lenet_pkg::weight_row_t w,
        input lenet_pkg::act_row_u    a,
        input int                     col
    );
        logic signed [2*`LENET_PIXEL_BITS-1:0] prod;
        lenet_pkg::partial_t                   total;
        total = '0;
        for (int i = 0; i < `LENET_KERNEL; i++) begin
            prod  = w[i] * a.pixels[col + i];
            total = total + lenet_pkg::partial_t'(prod);
        end
        return total;
    endfunction

    always_comb begin
        lenet_pkg::weight_row_t w;
        logic                   en;
        lenet_pkg::partial_t    base;
        lenet_pkg::partial_t    term;
        for (int r = 0; r < ROWS; r++) begin
            w  = (r == 0) ? feed.w0 : feed.w1;
            en = (r == 0) ? feed.en0 : feed.en1;
            for (int c = 0; c < COLS; c++) begin
                // beat 0 restarts every PE, even the idle lower row
                base           = feed.first ? '0 : acc[r][c];
                term           = en ? dot5(w, feed.act, c) : '0;
                acc_next[r][c] = base + term;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (feed.valid) begin
            acc <= acc_next;
        end
        // snapshot frees acc for the next frame straight away
        if (feed.valid && feed.last) begin
            snap <= acc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_n) begin
            snap_valid <= 1'b0;
        end else begin
            snap_valid <= feed.valid && feed.last;
        end
    end

    always_comb begin
        sums.valid = snap_valid;
        sums.pe    = snap;
    end

    // a one-beat frame cannot exist, beats 0 and 5 are distinct
    first_not_last: assert property (
        @(posedge clk) disable iff (!rst_n_n) feed.valid |-> !(feed.first && feed.last)
    );

endmodule

// ==== hw/window_feeder.sv ====
`timescale 1ns/1ns
`include "lenet_defines.svh"

module window_feeder (
    input  logic                   clk,
    input  logic                   rst_n_n,
    input  logic                   row_valid,
    input  logic                   row_first,
    input  lenet_pkg::act_row_u    act_words,
    input  lenet_pkg::weight_row_t weight_row,
    output lenet_pkg::feed_t       feed
);

    // beat count parks here once a frame is complete
    localparam logic [2:0] NO_FRAME   = 3'(`LENET_FRAME_ROWS);
    localparam logic [2:0] LAST_BEAT  = 3'(`LENET_FRAME_ROWS - 1);
    localparam logic [2:0] KERNEL_END = 3'(`LENET_KERNEL);

    logic [2:0]             next_beat;
    logic [2:0]             cur_beat;
    logic                   take;

    logic                   valid_q;
    logic                   first_q;
    logic                   last_q;
    logic                   en0_q;
    logic                   en1_q;
    lenet_pkg::weight_row_t w0_q;
    lenet_pkg::weight_row_t w1_q;
    lenet_pkg::weight_row_t prev_w;
    lenet_pkg::act_row_u    act_q;

    // row_first always restarts, stray beats past beat 5 are dropped
    assign cur_beat = row_first ? 3'd0 : next_beat;
    assign take     = row_valid && (row_first || next_beat != NO_FRAME);

    always_ff @(posedge clk) begin
        if (!rst_n_n) begin
            next_beat <= NO_FRAME;
            valid_q   <= 1'b0;
            first_q   <= 1'b0;
            last_q    <= 1'b0;
            en0_q     <= 1'b0;
            en1_q     <= 1'b0;
        end else begin
            valid_q <= take;
            first_q <= take && cur_beat == 3'd0;
            last_q  <= take && cur_beat == LAST_BEAT;
            // upper PE row on beats 0..4, lower row on beats 1..5
            en0_q   <= take && cur_beat < KERNEL_END;
            en1_q   <= take && cur_beat != 3'd0;
            if (take) begin
                next_beat <= cur_beat + 3'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            w0_q   <= weight_row;
            w1_q   <= prev_w;
            prev_w <= weight_row;
            act_q  <= act_words;
        end
    end

    always_comb begin
        feed.valid = valid_q;
        feed.first = first_q;
        feed.last  = last_q;
        feed.en0   = en0_q;
        feed.en1   = en1_q;
        feed.w0    = w0_q;
        feed.w1    = w1_q;
        feed.act   = act_q;
    end

    // an unknown strobe would corrupt the beat count silently
    row_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n_n) !$isunknown(row_valid)
    );

endmodule

// ==== hw/lenet_pkg.sv ====
`include "lenet_defines.svh"

package lenet_pkg;

    // one signed int8 pixel or weight
    typedef logic signed [`LENET_PIXEL_BITS-1:0] pixel_t;

    // tap 0 sits in the low byte
    typedef pixel_t [`LENET_KERNEL-1:0] weight_row_t;

    // activation row as read from memory (word 0 low) or as eight pixels
    typedef union packed {
        logic [1:0][`LENET_WORD_BITS-1:0]  words;
        pixel_t [`LENET_ROW_PIXELS-1:0]    pixels;
    } act_row_u;

    typedef logic signed [`LENET_PARTIAL_BITS-1:0] partial_t;

    // one frame beat towards the PE array
    typedef struct packed {
        logic        valid;
        logic        first;
        logic        last;
        logic        en0;
        logic        en1;
        weight_row_t w0;
        // weight of the previous beat, for the lower PE row
        weight_row_t w1;
        act_row_u    act;
    } feed_t;

    typedef struct packed {
        logic                                             valid;
        partial_t [`LENET_PE_ROWS-1:0][`LENET_PE_COLS-1:0] pe;
    } sums_t;

    // two pooled bytes in the low half
    typedef struct packed {
        logic [15:0] pad;
        pixel_t      q1;
        pixel_t      q0;
    } pool_result_t;

endpackage

// ==== hw/lenet_defines.svh ====
`ifndef LENET_DEFINES_SVH
`define LENET_DEFINES_SVH

// int8 activations and weights
`define LENET_PIXEL_BITS    8

// 5x5 kernel, one weight row per beat
`define LENET_KERNEL        5

// activation rows in one frame and pixels per row
`define LENET_FRAME_ROWS    6
`define LENET_ROW_PIXELS    8

// memory word carrying four pixels
`define LENET_WORD_BITS     32

// accumulator and quantiser widths
`define LENET_PARTIAL_BITS  25
`define LENET_SCALE_BITS    16
`define LENET_QUANT_SHIFT   16

// PE grid follows from frame and kernel size
`define LENET_PE_ROWS       (`LENET_FRAME_ROWS - `LENET_KERNEL + 1)
`define LENET_PE_COLS       (`LENET_ROW_PIXELS - `LENET_KERNEL + 1)

`endif
